// ==== sim.f ====
verilog/console_pkg.sv
verilog/button_conditioner.sv
verilog/session_controller.sv
verilog/sequence_game.sv
verilog/recipe_game.sv
verilog/status_display.sv
verilog/console_top.sv
tests/console_tb.sv

// ==== tests/console_vectors.txt ====
# game level count p0 p1 p2 p3 p4 p5 p6 p7 score code move(hex)
# game 0 is the sequence game, 1 the recipe game; only the first count presses are driven
0 0 4 3 0 5 1 0 0 0 0 4 6 02
0 1 8 3 0 5 1 6 2 4 0 8 6 01
0 1 8 3 0 6 1 6 2 4 0 2 6 40
0 0 4 2 3 0 5 0 0 0 0 0 6 04
1 0 4 1 4 2 6 0 0 0 0 4 6 40
1 1 6 1 0 2 3 0 6 0 0 3 6 40
1 0 4 0 0 0 0 0 0 0 0 0 6 01
1 1 8 1 4 5 6 3 5 2 2 4 6 20
1 1 6 1 4 2 6 0 5 0 0 6 6 20

// ==== tests/console_tb.sv ====
// Console testbench: clock, reset, vector reader, press driver, compare tasks and watchdog
`timescale 1ns/1ps

module console_tb;
    import console_pkg::*;

    localparam int MAX_VECTORS = 16;
    localparam int MAX_PRESSES = 8;

    logic                   clock;
    logic                   reset;
    logic                   start_n;
    logic                   difficulty;
    logic [1:0]             minigame;
    logic [NUM_BUTTONS-1:0] buttons_n;
    logic [1:0]             minigame_out;
    logic [3:0]             status_code;
    logic [NUM_BUTTONS-1:0] move_out;
    logic [3:0]             score_out;
    logic                   game_done;
    logic [6:0]             status_segments;

    // One entry per game line of the vector file
    logic [1:0]             vec_game  [MAX_VECTORS];
    logic                   vec_level [MAX_VECTORS];
    int                     vec_count [MAX_VECTORS];
    int                     vec_press [MAX_VECTORS][MAX_PRESSES];
    logic [3:0]             vec_score [MAX_VECTORS];
    logic [3:0]             vec_code  [MAX_VECTORS];
    logic [NUM_BUTTONS-1:0] vec_move  [MAX_VECTORS];
    int                     num_vectors;
    logic                   vectors_loaded;

    console_top dut0 (
        .clock           (clock),
        .reset           (reset),
        .start_n         (start_n),
        .difficulty      (difficulty),
        .minigame        (minigame),
        .buttons_n       (buttons_n),
        .minigame_out    (minigame_out),
        .status_code     (status_code),
        .move_out        (move_out),
        .score_out       (score_out),
        .game_done       (game_done),
        .status_segments (status_segments)
    );

    always #10 clock = ~clock;

    //----------------------------------------------------------------------
    // Failure reporting and compare tasks
    //----------------------------------------------------------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_score(input logic [3:0] actual, input logic [3:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s score %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_code(input logic [3:0] actual, input logic [3:0] expected,
                              input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s game code %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_move(input logic [NUM_BUTTONS-1:0] actual,
                              input logic [NUM_BUTTONS-1:0] expected, input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s move %h, expected %h",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_session_code(input logic [3:0] actual, input logic [3:0] expected,
                                      input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s session code %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_done(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s game_done %b, expected %b",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_selection(input logic [1:0] actual, input logic [1:0] expected,
                                   input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s minigame %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_segments(input logic [6:0] actual, input logic [6:0] expected,
                                  input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s segments %b, expected %b",
                                        $time, what, actual, expected));
        end
    endtask

    // Lit segments of a hex digit, bit 0 is segment a, high means lit
    function automatic logic [6:0] lit_segments(input logic [3:0] code);
        case (code)
            4'd0: return 7'h3f;
            4'd1: return 7'h06;
            4'd2: return 7'h5b;
            4'd3: return 7'h4f;
            4'd4: return 7'h66;
            4'd5: return 7'h6d;
            4'd6: return 7'h7d;
            default: return 7'h00;
        endcase
    endfunction

    //----------------------------------------------------------------------
    // Vector reader and pin drivers
    //----------------------------------------------------------------------
    task automatic load_vectors();
        int    fd;
        int    fields;
        int    g;
        int    l;
        int    n;
        int    sc;
        int    cd;
        int    mv;
        int    p [MAX_PRESSES];
        string line;
        fd = $fopen("tests/console_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the vector file tests/console_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip column comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %h",
                                 g, l, n, p[0], p[1], p[2], p[3], p[4], p[5], p[6], p[7],
                                 sc, cd, mv);
                if (fields != 14 || num_vectors >= MAX_VECTORS || n > MAX_PRESSES) begin
                    stop_with_failure($sformatf("Bad line in the vector file: %s", line));
                end
                vec_game[num_vectors]  = g[1:0];
                vec_level[num_vectors] = l[0];
                vec_count[num_vectors] = n;
                for (int i = 0; i < MAX_PRESSES; i++) begin
                    vec_press[num_vectors][i] = p[i];
                end
                vec_score[num_vectors] = sc[3:0];
                vec_code[num_vectors]  = cd[3:0];
                vec_move[num_vectors]  = mv[NUM_BUTTONS-1:0];
                num_vectors++;
            end
        end
        $fclose(fd);
        if (num_vectors == 0) begin
            stop_with_failure("The vector file holds no games");
        end
        vectors_loaded = 1'b1;
    endtask

    // Ends 2 ns after a rising edge, where inputs change
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clock);
        #2;
    endtask

    task automatic press_start();
        start_n = 1'b0;
        step_cycles(4);
        start_n = 1'b1;
        step_cycles(4);
    endtask

    task automatic press_button(input int index);
        buttons_n = ~(NUM_BUTTONS'(1) << index);
        step_cycles(4);
        buttons_n = '1;
        step_cycles(4);
    endtask

    // Samples the display once per cycle while an invalid game is selected
    task automatic expect_prepare(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clock);
            check_session_code(status_code, CODE_PREPARE, "invalid selection");
            check_segments(status_segments, ~lit_segments(CODE_PREPARE), "invalid selection");
        end
    endtask

    //----------------------------------------------------------------------
    // One session per vector
    //----------------------------------------------------------------------
    task automatic play_vector(input int v, input bit invalid_first);
        string tag;
        tag = $sformatf("vector %0d", v);
        step_cycles(1);
        difficulty = vec_level[v];
        if (invalid_first) begin
            // Invalid codes keep the console in prepare
            minigame = 2'd2;
            press_start();
            expect_prepare(50);
            step_cycles(1);
            minigame = 2'd3;
            expect_prepare(50);
            step_cycles(1);
            minigame = vec_game[v];
            @(negedge clock);
            while (status_code == CODE_PREPARE) begin
                @(negedge clock);
            end
            check_session_code(status_code, CODE_PAUSE, "valid selection");
            check_segments(status_segments, ~lit_segments(CODE_PAUSE), "valid selection");
        end else begin
            minigame = vec_game[v];
            press_start();
        end
        // game_done stays low until the new game is running
        @(negedge clock);
        while (status_code != CODE_ACTIVE) begin
            check_done(game_done, 1'b0, tag);
            @(negedge clock);
        end
        check_done(game_done, 1'b0, tag);
        step_cycles(1);
        for (int p = 0; p < vec_count[v]; p++) begin
            press_button(vec_press[v][p]);
        end
        @(negedge clock);
        while (game_done !== 1'b1) begin
            @(negedge clock);
        end
        check_score(score_out, vec_score[v], tag);
        check_code(status_code, vec_code[v], tag);
        check_segments(status_segments, ~lit_segments(vec_code[v]), tag);
        check_move(move_out, vec_move[v], tag);
        check_selection(minigame_out, vec_game[v], tag);
    endtask

    initial begin : watchdog
        int limit;
        wait (vectors_loaded === 1'b1);
        limit = num_vectors * (PAUSE_CYCLES + 20 + 8 * 8) + 300;
        repeat (limit) @(posedge clock);
        stop_with_failure("Timeout: the console never reported done");
    end

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        start_n        = 1'b1;
        difficulty     = 1'b0;
        minigame       = 2'd0;
        buttons_n      = '1;
        num_vectors    = 0;
        vectors_loaded = 1'b0;
        load_vectors();
        step_cycles(10);
        reset = 1'b0;
        @(negedge clock);
        check_session_code(status_code, CODE_IDLE, "after reset");
        check_segments(status_segments, ~lit_segments(CODE_IDLE), "after reset");
        check_done(game_done, 1'b0, "after reset");
        check_score(score_out, 4'd0, "after reset");
        check_move(move_out, '0, "after reset");
        check_selection(minigame_out, 2'd0, "after reset");
        for (int v = 0; v < num_vectors; v++) begin
            play_vector(v, v == 0);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog/console_top.sv ====
// Console top: conditioner, session controller, both minigames and status display
`timescale 1ns/1ps

module console_top (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                start_n,
    input  logic                                difficulty,
    input  logic [1:0]                          minigame,
    input  logic [console_pkg::NUM_BUTTONS-1:0] buttons_n,
    output logic [1:0]                          minigame_out,
    output logic [3:0]                          status_code,
    output logic [console_pkg::NUM_BUTTONS-1:0] move_out,
    output logic [3:0]                          score_out,
    output logic                                game_done,
    output logic [6:0]                          status_segments
);
    import console_pkg::*;

    button_event_t  events;
    session_state_t session_state;
    game_status_t   status_0;
    game_status_t   status_1;
    logic [1:0]     selected_game;
    logic [1:0]     launch;
    logic           level;
    logic           selected_done;

    // Game 0 is the sequence game, game 1 the recipe game
    assign selected_done = selected_game[0] ? status_1.done : status_0.done;
    assign minigame_out  = selected_game;

    button_conditioner conditioner0 (
        .clock     (clock),
        .reset     (reset),
        .start_n   (start_n),
        .buttons_n (buttons_n),
        .events    (events)
    );

    session_controller controller0 (
        .clock         (clock),
        .reset         (reset),
        .start         (events.start),
        .minigame      (minigame),
        .difficulty    (difficulty),
        .selected_done (selected_done),
        .state         (session_state),
        .selected_game (selected_game),
        .level         (level),
        .launch        (launch)
    );

    sequence_game sequence0 (
        .clock  (clock),
        .reset  (reset),
        .launch (launch[0]),
        .level  (level),
        .press  (events.press),
        .status (status_0)
    );

    recipe_game recipe0 (
        .clock  (clock),
        .reset  (reset),
        .launch (launch[1]),
        .level  (level),
        .press  (events.press),
        .status (status_1)
    );

    status_display display0 (
        .state         (session_state),
        .selected_game (selected_game),
        .status_0      (status_0),
        .status_1      (status_1),
        .status_code   (status_code),
        .move_out      (move_out),
        .score_out     (score_out),
        .game_done     (game_done),
        .segments      (status_segments)
    );

endmodule

// ==== verilog/status_display.sv ====
// Status display: game status mux, session code substitution and seven-segment decoder
`timescale 1ns/1ps

module status_display (
    input  console_pkg::session_state_t         state,
    input  logic [1:0]                          selected_game,
    input  console_pkg::game_status_t           status_0,
    input  console_pkg::game_status_t           status_1,
    output logic [3:0]                          status_code,
    output logic [console_pkg::NUM_BUTTONS-1:0] move_out,
    output logic [3:0]                          score_out,
    output logic                                game_done,
    output logic [6:0]                          segments
);
    import console_pkg::*;

    game_status_t selected;

    assign selected = selected_game[0] ? status_1 : status_0;

    //----------------------------------------------------------------------
    // Code selection
    //----------------------------------------------------------------------
    always_comb begin
        status_code = CODE_IDLE;
        move_out    = '0;
        score_out   = 4'd0;
        game_done   = 1'b0;
        case (state)
            SESSION_PREPARE: status_code = CODE_PREPARE;
            // Launch is a single cycle, shown as part of the pause
            SESSION_PAUSE,
            SESSION_LAUNCH:  status_code = CODE_PAUSE;
            SESSION_PLAY: begin
                status_code = selected.state_code;
                move_out    = selected.last_move;
                score_out   = selected.score;
            end
            SESSION_FINISHED: begin
                status_code = selected.state_code;
                move_out    = selected.last_move;
                score_out   = selected.score;
                game_done   = selected.done;
            end
            default: status_code = CODE_IDLE;
        endcase
    end

    // Hex digit, segments ordered g down to a, low means lit
    always_comb begin
        case (status_code)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            4'ha: segments = 7'b0001000;
            4'hb: segments = 7'b0000011;
            4'hc: segments = 7'b1000110;
            4'hd: segments = 7'b0100001;
            4'he: segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

// ==== verilog/recipe_game.sv ====
// Recipe game: score a fixed number of ingredient presses against the recipe table
`timescale 1ns/1ps

module recipe_game (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                launch,
    input  logic                                level,
    input  logic [console_pkg::NUM_BUTTONS-1:0] press,
    output console_pkg::game_status_t           status
);
    import console_pkg::*;

    game_state_t            state;
    logic [3:0]             position;
    logic [3:0]             score;
    logic [NUM_BUTTONS-1:0] last_move;
    logic                   done;
    logic [3:0]             recipe_len;
    logic                   press_valid;
    logic                   press_match;
    logic                   last_step;

    assign recipe_len  = level ? RECIPE_LEN_HARD : RECIPE_LEN_EASY;
    assign press_valid = (state == GAME_ACTIVE) && (press != '0);
    assign press_match = onehot_to_index(press) == RECIPE_TABLE[position[2:0]];
    assign last_step   = (position + 4'd1) == recipe_len;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= GAME_WAITING;
            position  <= 4'd0;
            score     <= 4'd0;
            last_move <= '0;
            done      <= 1'b0;
        end else if (launch) begin
            state     <= GAME_ACTIVE;
            position  <= 4'd0;
            score     <= 4'd0;
            last_move <= '0;
            done      <= 1'b0;
        end else if (press_valid) begin
            // Every ingredient uses up a slot, right or wrong
            last_move <= press;
            position  <= position + 4'd1;
            score     <= score + {3'd0, press_match};
            if (last_step) begin
                state <= GAME_OVER;
                done  <= 1'b1;
            end
        end
    end

    assign status = '{
        state_code: game_state_code(state),
        last_move:  last_move,
        score:      score,
        done:       done
    };

endmodule

// ==== verilog/sequence_game.sv ====
// Sequence game: repeat the stored button sequence, ending at the first mistake
`timescale 1ns/1ps

module sequence_game (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                launch,
    input  logic                                level,
    input  logic [console_pkg::NUM_BUTTONS-1:0] press,
    output console_pkg::game_status_t           status
);
    import console_pkg::*;

    game_state_t            state;
    logic [3:0]             position;
    logic [3:0]             score;
    logic [NUM_BUTTONS-1:0] last_move;
    logic                   done;
    logic [3:0]             seq_len;
    logic                   press_valid;
    logic                   press_correct;
    logic                   last_step;

    assign seq_len       = level ? SEQ_LEN_HARD : SEQ_LEN_EASY;
    assign press_valid   = (state == GAME_ACTIVE) && (press != '0);
    assign press_correct = onehot_to_index(press) == SEQUENCE_TABLE[position[2:0]];
    assign last_step     = (position + 4'd1) == seq_len;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= GAME_WAITING;
            position  <= 4'd0;
            score     <= 4'd0;
            last_move <= '0;
            done      <= 1'b0;
        end else if (launch) begin
            state     <= GAME_ACTIVE;
            position  <= 4'd0;
            score     <= 4'd0;
            last_move <= '0;
            done      <= 1'b0;
        end else if (press_valid) begin
            last_move <= press;
            if (press_correct) begin
                score    <= score + 4'd1;
                position <= position + 4'd1;
                // Whole sequence repeated
                if (last_step) begin
                    state <= GAME_OVER;
                    done  <= 1'b1;
                end
            end else begin
                state <= GAME_OVER;
                done  <= 1'b1;
            end
        end
    end

    assign status = '{
        state_code: game_state_code(state),
        last_move:  last_move,
        score:      score,
        done:       done
    };

endmodule

// ==== verilog/session_controller.sv ====
// Session controller: session FSM, pause counter, selection latch and game launch pulses
`timescale 1ns/1ps

module session_controller (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        start,
    input  logic [1:0]                  minigame,
    input  logic                        difficulty,
    input  logic                        selected_done,
    output console_pkg::session_state_t state,
    output logic [1:0]                  selected_game,
    output logic                        level,
    output logic [1:0]                  launch
);
    import console_pkg::*;

    session_state_t           next_state;
    logic [PAUSE_COUNT_W-1:0] pause_count;
    logic                     pause_done;
    logic                     selection_valid;
    logic                     latch_selection;

    assign selection_valid = selected_game < 2'(NUM_GAMES);
    assign pause_done      = pause_count == PAUSE_COUNT_W'(PAUSE_CYCLES - 1);

    // Sample on the start press too, so prepare judges the fresh choice
    assign latch_selection = (state == SESSION_PREPARE) ||
                             (start && (state == SESSION_IDLE || state == SESSION_FINISHED));

    //----------------------------------------------------------------------
    // State register and next state
    //----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= SESSION_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SESSION_IDLE: begin
                if (start) begin
                    next_state = SESSION_PREPARE;
                end
            end
            SESSION_PREPARE: begin
                if (selection_valid) begin
                    next_state = SESSION_PAUSE;
                end
            end
            SESSION_PAUSE: begin
                if (pause_done) begin
                    next_state = SESSION_LAUNCH;
                end
            end
            SESSION_LAUNCH: next_state = SESSION_PLAY;
            SESSION_PLAY: begin
                if (selected_done) begin
                    next_state = SESSION_FINISHED;
                end
            end
            SESSION_FINISHED: begin
                if (start) begin
                    next_state = SESSION_PREPARE;
                end
            end
            default: next_state = SESSION_IDLE;
        endcase
    end

    //----------------------------------------------------------------------
    // Pause counter and selection latch
    //----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pause_count   <= '0;
            selected_game <= 2'd0;
            level         <= 1'b0;
        end else begin
            // Held at zero outside pause
            if (state == SESSION_PAUSE) begin
                pause_count <= pause_count + PAUSE_COUNT_W'(1);
            end else begin
                pause_count <= '0;
            end
            if (latch_selection) begin
                selected_game <= minigame;
                level         <= difficulty;
            end
        end
    end

    // One launch bit, for the chosen game only
    assign launch = (state == SESSION_LAUNCH) ? (2'b01 << selected_game) : 2'b00;

endmodule

// ==== verilog/button_conditioner.sv ====
// Button conditioner: pin inversion, two-flop synchronizer and rising-edge press pulses
`timescale 1ns/1ps

module button_conditioner (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                start_n,
    input  logic [console_pkg::NUM_BUTTONS-1:0] buttons_n,
    output console_pkg::button_event_t          events
);
    import console_pkg::*;

    // Bit NUM_BUTTONS is start, the rest are the game buttons
    logic [NUM_BUTTONS:0]   pins;
    logic [NUM_BUTTONS:0]   sync_1;
    logic [NUM_BUTTONS:0]   sync_2;
    logic [NUM_BUTTONS:0]   level_prev;
    logic [NUM_BUTTONS:0]   rising;
    logic [NUM_BUTTONS-1:0] rising_buttons;
    logic [NUM_BUTTONS-1:0] press_lowest;

    // Board buttons pull low when pressed
    assign pins = ~{start_n, buttons_n};

    assign rising         = sync_2 & ~level_prev;
    assign rising_buttons = rising[NUM_BUTTONS-1:0];

    // Keep only the lowest set bit
    assign press_lowest = rising_buttons & (~rising_buttons + NUM_BUTTONS'(1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_1     <= '0;
            sync_2     <= '0;
            level_prev <= '0;
            events     <= '0;
        end else begin
            sync_1       <= pins;
            sync_2       <= sync_1;
            level_prev   <= sync_2;
            events.start <= rising[NUM_BUTTONS];
            events.press <= press_lowest;
        end
    end

endmodule

// ==== verilog/console_pkg.sv ====
// Console package: states, status codes, event and status structs, game tables and timing
package console_pkg;

    //----------------------------------------------------------------------
    // Sizes and timing
    //----------------------------------------------------------------------
    localparam int NUM_BUTTONS   = 7;
    localparam int NUM_GAMES     = 2;
    localparam int PAUSE_CYCLES  = 20;
    localparam int PAUSE_COUNT_W = $clog2(PAUSE_CYCLES);

    // Status codes shown on the display
    localparam logic [3:0] CODE_IDLE     = 4'd0;
    localparam logic [3:0] CODE_PAUSE    = 4'd1;
    localparam logic [3:0] CODE_PREPARE  = 4'd2;
    localparam logic [3:0] CODE_FINISHED = 4'd3;
    localparam logic [3:0] CODE_WAITING  = 4'd4;
    localparam logic [3:0] CODE_ACTIVE   = 4'd5;
    localparam logic [3:0] CODE_OVER     = 4'd6;

    //----------------------------------------------------------------------
    // Game tables, entries are button indices
    //----------------------------------------------------------------------
    localparam logic [2:0] SEQUENCE_TABLE [0:7] = '{
        3'd3, 3'd0, 3'd5, 3'd1, 3'd6, 3'd2, 3'd4, 3'd0
    };
    localparam logic [3:0] SEQ_LEN_EASY = 4'd4;
    localparam logic [3:0] SEQ_LEN_HARD = 4'd8;

    localparam logic [2:0] RECIPE_TABLE [0:5] = '{
        3'd1, 3'd4, 3'd2, 3'd6, 3'd0, 3'd5
    };
    localparam logic [3:0] RECIPE_LEN_EASY = 4'd4;
    localparam logic [3:0] RECIPE_LEN_HARD = 4'd6;

    typedef enum logic [2:0] {
        SESSION_IDLE,
        SESSION_PREPARE,
        SESSION_PAUSE,
        SESSION_LAUNCH,
        SESSION_PLAY,
        SESSION_FINISHED
    } session_state_t;

    typedef enum logic [1:0] {
        GAME_WAITING,
        GAME_ACTIVE,
        GAME_OVER
    } game_state_t;

    typedef struct packed {
        logic                   start;
        logic [NUM_BUTTONS-1:0] press;
    } button_event_t;

    typedef struct packed {
        logic [3:0]             state_code;
        logic [NUM_BUTTONS-1:0] last_move;
        logic [3:0]             score;
        logic                   done;
    } game_status_t;

    // One-hot press to button index
    function automatic logic [2:0] onehot_to_index(input logic [NUM_BUTTONS-1:0] onehot);
        logic [2:0] index;
        index = 3'd0;
        for (int i = 0; i < NUM_BUTTONS; i++) begin
            if (onehot[i]) begin
                index = i[2:0];
            end
        end
        return index;
    endfunction

    function automatic logic [3:0] game_state_code(input game_state_t game_state);
        case (game_state)
            GAME_ACTIVE: return CODE_ACTIVE;
            GAME_OVER:   return CODE_OVER;
            default:     return CODE_WAITING;
        endcase
    endfunction

endpackage
